/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = mem_tb
FILE_LIST = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sources.f */
+incdir+src
src/mem_pkg.sv
src/dcache_if.sv
src/csr_if.sv
src/mem_stage.sv
src/data_cache.sv
src/csr_file.sv
src/wb_stage.sv
src/mem_top.sv
verif/mem_asserts.sv
verif/mem_tb.sv

/* src/csr_file.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module csr_file (
    input  logic  clk,
    input  logic  rst_n,
    csr_if.file   csr
);
    logic [`DATA_W-1:0] crmd_q;
    logic [`DATA_W-1:0] estat_q;
    logic [`DATA_W-1:0] era_q;
    logic [`DATA_W-1:0] save0_q;
    logic [`DATA_W-1:0] tid_q;
    logic [63:0]        cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_q  <= 32'h0000_0008;   // DA set
            estat_q <= '0;
            era_q   <= '0;
            save0_q <= '0;
            tid_q   <= '0;
            cnt_q   <= '0;
        end else begin
            cnt_q <= cnt_q + 64'd1;
            if (csr.wr_en) begin
                case (csr.wr_addr)
                    `CSR_CRMD:  crmd_q  <= csr.wr_data;
                    `CSR_ESTAT: estat_q <= (estat_q & ~`ESTAT_WR_MASK) |
                                           (csr.wr_data & `ESTAT_WR_MASK);
                    `CSR_ERA:   era_q   <= csr.wr_data;
                    `CSR_SAVE0: save0_q <= csr.wr_data;
                    `CSR_TID:   tid_q   <= csr.wr_data;
                    default: ;   // Unknown CSR
                endcase
            end
        end
    end

    always_comb begin
        csr.rd_data = '0;
        if (csr.rd_en) begin
            case (csr.rd_addr)
                `CSR_CRMD:  csr.rd_data = crmd_q;
                `CSR_ESTAT: csr.rd_data = estat_q;
                `CSR_ERA:   csr.rd_data = era_q;
                `CSR_SAVE0: csr.rd_data = save0_q;
                `CSR_TID:   csr.rd_data = tid_q;
                default:    csr.rd_data = '0;
            endcase
        end
    end

    assign csr.cnt = cnt_q;
endmodule

/* src/csr_if.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

interface csr_if;
    logic               rd_en;
    logic [13:0]        rd_addr;
    logic [`DATA_W-1:0] rd_data;   // Combinational read
    logic               wr_en;
    logic [13:0]        wr_addr;
    logic [`DATA_W-1:0] wr_data;
    logic [63:0]        cnt;       // Stable counter

    modport reader (output rd_en, rd_addr, input rd_data, cnt);

    modport writer (output wr_en, wr_addr, wr_data);

    modport file   (input  rd_en, rd_addr, wr_en, wr_addr, wr_data,
                    output rd_data, cnt);
endinterface

/* src/data_cache.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module data_cache (
    input  logic     clk,
    input  logic     rst_n,
    dcache_if.slave  dc
);
    localparam int IDX_W  = $clog2(`CACHE_LINES);
    localparam int RAM_AW = $clog2(`RAM_WORDS);
    localparam int TAG_W  = `DATA_W - 2 - IDX_W;
    localparam int CNT_W  = $clog2(`REFILL_CYCLES + 1);

    logic [TAG_W-1:0]     tag_mem  [`CACHE_LINES];
    logic [`DATA_W-1:0]   data_mem [`CACHE_LINES];
    logic [`DATA_W-1:0]   ram      [`RAM_WORDS];
    logic [`CACHE_LINES-1:0] valid_q;
    mem_pkg::cache_state_e state_q;
    logic [CNT_W-1:0]     cnt_q;

    logic [IDX_W-1:0]     idx;
    logic [TAG_W-1:0]     tag;
    logic [RAM_AW-1:0]    ram_idx;
    logic                 hit;
    logic                 fill_done;

    initial begin
        for (int i = 0; i < `RAM_WORDS; i++)
            ram[i] = '0;
    end

    assign idx       = dc.addr[IDX_W+1:2];
    assign tag       = dc.addr[`DATA_W-1:IDX_W+2];
    assign ram_idx   = dc.addr[RAM_AW+1:2];
    assign hit       = valid_q[idx] && tag_mem[idx] == tag;
    assign fill_done = state_q == mem_pkg::CS_REFILL && cnt_q == CNT_W'(`REFILL_CYCLES - 1);

    assign dc.data_ok    = dc.req && state_q == mem_pkg::CS_IDLE && (dc.we || hit);
    assign dc.cache_miss = dc.req && !dc.we && !(state_q == mem_pkg::CS_IDLE && hit);
    assign dc.rdata      = data_mem[idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= mem_pkg::CS_IDLE;
            cnt_q   <= '0;
            valid_q <= '0;
        end else begin
            case (state_q)
                mem_pkg::CS_IDLE: begin
                    if (dc.req && !dc.we && !hit) begin
                        state_q <= mem_pkg::CS_REFILL;
                        cnt_q   <= '0;
                    end
                end
                default: begin
                    if (fill_done) begin
                        state_q      <= mem_pkg::CS_IDLE;
                        valid_q[idx] <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= ram[ram_idx];
        end
        if (dc.req && dc.we && state_q == mem_pkg::CS_IDLE) begin   // Write-through, no allocate
            for (int b = 0; b < 4; b++) begin
                if (dc.byte_en[b]) begin
                    ram[ram_idx][8*b +: 8] <= dc.wdata[8*b +: 8];
                    if (hit)
                        data_mem[idx][8*b +: 8] <= dc.wdata[8*b +: 8];
                end
            end
        end
    end
endmodule

/* src/dcache_if.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

interface dcache_if;
    logic               req;
    logic               we;
    logic [3:0]         byte_en;
    logic [`DATA_W-1:0] addr;
    logic [`DATA_W-1:0] wdata;
    logic               data_ok;
    logic               cache_miss;
    logic [`DATA_W-1:0] rdata;

    // Request side held steady until data_ok
    modport master (output req, we, byte_en, addr, wdata,
                    input  data_ok, cache_miss, rdata);

    modport slave  (input  req, we, byte_en, addr, wdata,
                    output data_ok, cache_miss, rdata);
endinterface

/* src/mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Datapath and address width
`define DATA_W        32

// Data cache geometry, one word per line
`define CACHE_LINES   16
`define RAM_WORDS     256
`define REFILL_CYCLES 3

// CSR addresses
`define CSR_CRMD      14'h000
`define CSR_ESTAT     14'h005
`define CSR_ERA       14'h006
`define CSR_SAVE0     14'h030
`define CSR_TID       14'h040

// ESTAT software interrupt bits
`define ESTAT_WR_MASK 32'h0000_0003

`endif

/* src/mem_pkg.sv */
`include "mem_config.svh"

package mem_pkg;

    typedef enum logic [4:0] {
        OP_NONE    = 5'd0,
        OP_ALU     = 5'd1,   // Execute result straight to rd
        OP_LDB     = 5'd2,
        OP_LDBU    = 5'd3,
        OP_LDH     = 5'd4,
        OP_LDHU    = 5'd5,
        OP_LDW     = 5'd6,
        OP_LLW     = 5'd7,
        OP_STB     = 5'd8,
        OP_STH     = 5'd9,
        OP_STW     = 5'd10,
        OP_CSRRD   = 5'd11,
        OP_CSRWR   = 5'd12,
        OP_CSRXCHG = 5'd13,
        OP_RDCNTID = 5'd14,
        OP_RDCNTVL = 5'd15,
        OP_RDCNTVH = 5'd16
    } mem_op_e;

    typedef enum logic {
        CS_IDLE,
        CS_REFILL
    } cache_state_e;

    typedef struct packed {
        logic               en;
        logic [4:0]         addr;
        logic [`DATA_W-1:0] data;
    } reg_write_t;

    typedef struct packed {
        logic               en;
        logic [13:0]        addr;
        logic [`DATA_W-1:0] data;
    } csr_write_t;

endpackage

/* src/mem_stage.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  mem_pkg::mem_op_e     in_op,
    input  logic [`DATA_W-1:0]   in_addr,
    input  logic [`DATA_W-1:0]   in_store_data,
    input  logic [`DATA_W-1:0]   in_alu_result,
    input  logic [`DATA_W-1:0]   in_csr_wdata,
    input  logic [`DATA_W-1:0]   in_csr_mask,
    input  logic [4:0]           in_rd,
    input  logic [13:0]          in_csr_addr,
    dcache_if.master             dc,
    csr_if.reader                csr,
    input  mem_pkg::csr_write_t  fwd,
    output logic                 stall,
    output logic                 out_valid,
    output mem_pkg::reg_write_t  out_reg,
    output mem_pkg::csr_write_t  out_csr
);
    logic               is_load;
    logic               is_store;
    logic               is_csr_wr;
    logic [3:0]         st_be;
    logic [`DATA_W-1:0] st_data;
    logic [7:0]         ld_byte;
    logic [15:0]        ld_half;
    logic [`DATA_W-1:0] csr_old;
    logic [`DATA_W-1:0] cnt_hi_q;

    assign is_load   = in_op inside {mem_pkg::OP_LDB, mem_pkg::OP_LDBU, mem_pkg::OP_LDH,
                                     mem_pkg::OP_LDHU, mem_pkg::OP_LDW, mem_pkg::OP_LLW};
    assign is_store  = in_op inside {mem_pkg::OP_STB, mem_pkg::OP_STH, mem_pkg::OP_STW};
    assign is_csr_wr = in_op inside {mem_pkg::OP_CSRWR, mem_pkg::OP_CSRXCHG};

    always_comb begin
        case (in_op)
            mem_pkg::OP_STB: begin
                st_be   = 4'b0001 << in_addr[1:0];
                st_data = {4{in_store_data[7:0]}};   // Replicate into every lane
            end
            mem_pkg::OP_STH: begin
                st_be   = in_addr[1] ? 4'b1100 : 4'b0011;
                st_data = {2{in_store_data[15:0]}};
            end
            default: begin
                st_be   = 4'b1111;
                st_data = in_store_data;
            end
        endcase
    end

    assign dc.req     = in_valid && (is_load || is_store);
    assign dc.we      = is_store;
    assign dc.byte_en = st_be;
    assign dc.addr    = in_addr;
    assign dc.wdata   = st_data;

    // Loads wait for a hit, stores finish in their first cycle
    assign stall     = in_valid && is_load && !(dc.data_ok && !dc.cache_miss);
    assign out_valid = in_valid && !stall;

    assign ld_byte = dc.rdata[{in_addr[1:0], 3'b000} +: 8];
    assign ld_half = in_addr[1] ? dc.rdata[31:16] : dc.rdata[15:0];

    assign csr.rd_en   = in_valid && (in_op inside {mem_pkg::OP_CSRRD, mem_pkg::OP_CSRWR,
                                                    mem_pkg::OP_CSRXCHG, mem_pkg::OP_RDCNTID});
    assign csr.rd_addr = (in_op == mem_pkg::OP_RDCNTID) ? `CSR_TID : in_csr_addr;

    always_comb begin
        if (csr.rd_en && fwd.en && fwd.addr == csr.rd_addr) begin
            if (csr.rd_addr == `CSR_ESTAT)   // Only the writable ESTAT bits come from wb
                csr_old = (csr.rd_data & ~`ESTAT_WR_MASK) | (fwd.data & `ESTAT_WR_MASK);
            else
                csr_old = fwd.data;
        end else begin
            csr_old = csr.rd_data;
        end
    end

    // High half as sampled by the last rdcntvl.w, so a vl/vh pair is consistent
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_hi_q <= '0;
        end else if (out_valid && in_op == mem_pkg::OP_RDCNTVL) begin
            cnt_hi_q <= csr.cnt[63:32];
        end
    end

    always_comb begin
        out_reg.en   = !(is_store || in_op == mem_pkg::OP_NONE);
        out_reg.addr = in_rd;
        case (in_op)
            mem_pkg::OP_LDB:     out_reg.data = {{24{ld_byte[7]}}, ld_byte};
            mem_pkg::OP_LDBU:    out_reg.data = {24'b0, ld_byte};
            mem_pkg::OP_LDH:     out_reg.data = in_addr[0] ? '0 : {{16{ld_half[15]}}, ld_half};
            mem_pkg::OP_LDHU:    out_reg.data = in_addr[0] ? '0 : {16'b0, ld_half};
            mem_pkg::OP_LDW,
            mem_pkg::OP_LLW:     out_reg.data = dc.rdata;
            mem_pkg::OP_CSRRD,
            mem_pkg::OP_CSRWR,
            mem_pkg::OP_CSRXCHG,
            mem_pkg::OP_RDCNTID: out_reg.data = csr_old;
            mem_pkg::OP_RDCNTVL: out_reg.data = csr.cnt[31:0];
            mem_pkg::OP_RDCNTVH: out_reg.data = cnt_hi_q;
            default:             out_reg.data = in_alu_result;
        endcase
    end

    assign out_csr.en   = is_csr_wr;
    assign out_csr.addr = in_csr_addr;
    assign out_csr.data = (in_op == mem_pkg::OP_CSRXCHG) ?
                          ((csr_old & ~in_csr_mask) | (in_csr_wdata & in_csr_mask)) :
                          in_csr_wdata;
endmodule

/* src/mem_top.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  mem_pkg::mem_op_e   in_op,
    input  logic [`DATA_W-1:0] in_addr,
    input  logic [`DATA_W-1:0] in_store_data,
    input  logic [`DATA_W-1:0] in_alu_result,
    input  logic [4:0]         in_rd,
    input  logic [13:0]        in_csr_addr,
    input  logic [`DATA_W-1:0] in_csr_wdata,
    input  logic [`DATA_W-1:0] in_csr_mask,
    output logic               stall,
    output logic               wb_valid,
    output logic [4:0]         wb_rd,
    output logic [`DATA_W-1:0] wb_data
);
    logic                mem_valid;
    mem_pkg::reg_write_t mem_reg;
    mem_pkg::csr_write_t mem_csr;
    mem_pkg::csr_write_t wb_fwd;

    dcache_if dc_bus ();
    csr_if    csr_bus ();

    mem_stage mem_stage_i (
        .clk, .rst_n, .in_valid, .in_op, .in_addr, .in_store_data, .in_alu_result,
        .in_csr_wdata, .in_csr_mask, .in_rd, .in_csr_addr,
        .dc (dc_bus.master), .csr (csr_bus.reader), .fwd (wb_fwd),
        .stall, .out_valid (mem_valid), .out_reg (mem_reg), .out_csr (mem_csr)
    );

    data_cache data_cache_i (.clk, .rst_n, .dc (dc_bus.slave));

    csr_file csr_file_i (.clk, .rst_n, .csr (csr_bus.file));

    wb_stage wb_stage_i (
        .clk, .rst_n, .in_valid (mem_valid), .in_reg (mem_reg), .in_csr (mem_csr),
        .csr (csr_bus.writer), .fwd (wb_fwd), .wb_valid, .wb_rd, .wb_data
    );
endmodule

/* src/wb_stage.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module wb_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  mem_pkg::reg_write_t  in_reg,
    input  mem_pkg::csr_write_t  in_csr,
    csr_if.writer                csr,
    output mem_pkg::csr_write_t  fwd,
    output logic                 wb_valid,
    output logic [4:0]           wb_rd,
    output logic [`DATA_W-1:0]   wb_data
);
    logic               valid_q;
    logic               reg_en_q;
    logic               csr_en_q;
    logic [4:0]         reg_addr_q;
    logic [`DATA_W-1:0] reg_data_q;
    logic [13:0]        csr_addr_q;
    logic [`DATA_W-1:0] csr_data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            reg_en_q <= 1'b0;
            csr_en_q <= 1'b0;
        end else begin
            valid_q  <= in_valid;
            reg_en_q <= in_valid && in_reg.en;
            csr_en_q <= in_valid && in_csr.en;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            reg_addr_q <= in_reg.addr;
            reg_data_q <= in_reg.data;
            csr_addr_q <= in_csr.addr;
            csr_data_q <= in_csr.data;
        end
    end

    assign wb_valid = valid_q;
    assign wb_rd    = reg_en_q ? reg_addr_q : 5'd0;   // r0 when nothing is written
    assign wb_data  = reg_data_q;

    // Commits at the end of this cycle
    assign csr.wr_en   = csr_en_q;
    assign csr.wr_addr = csr_addr_q;
    assign csr.wr_data = csr_data_q;

    assign fwd = '{en: csr_en_q, addr: csr_addr_q, data: csr_data_q};
endmodule

/* verif/mem_asserts.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               in_valid,
    input logic               stall,
    input logic               wb_valid,
    input logic               dc_req,
    input logic               dc_we,
    input logic [3:0]         dc_byte_en,
    input logic [`DATA_W-1:0] dc_addr,
    input logic [`DATA_W-1:0] dc_wdata
);
    int stall_run_q;   // Stall cycles already seen in the current run

    always_ff @(posedge clk) begin
        if (!rst_n)
            stall_run_q <= 0;
        else
            stall_run_q <= stall ? stall_run_q + 1 : 0;
    end

    no_wb_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb_valid)
        else $error("wb_valid high in the first cycle after reset release");

    stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> stall_run_q <= `REFILL_CYCLES)
        else $error("stall lasted longer than a refill");

    wb_follows_accept: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !stall |=> wb_valid)
        else $error("accepted instruction did not reach write-back");

    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable({dc_req, dc_we, dc_byte_en, dc_addr, dc_wdata}))
        else $error("cache request changed during a stall");
endmodule

/* verif/mem_tb.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_tb;
    typedef struct packed {
        mem_pkg::mem_op_e op;
        logic [31:0]      addr;
        logic [31:0]      sdata;
        logic [31:0]      alu;
        logic [4:0]       rd;
        logic [13:0]      caddr;
        logic [31:0]      cdata;
        logic [31:0]      mask;
    } entry_t;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    mem_pkg::mem_op_e   in_op;
    logic [31:0]        in_addr;
    logic [31:0]        in_store_data;
    logic [31:0]        in_alu_result;
    logic [4:0]         in_rd;
    logic [13:0]        in_csr_addr;
    logic [31:0]        in_csr_wdata;
    logic [31:0]        in_csr_mask;
    logic               stall;
    logic               wb_valid;
    logic [4:0]         wb_rd;
    logic [31:0]        wb_data;

    entry_t             tbl[$];
    logic [31:0]        mem_m [`RAM_WORDS];
    logic [31:0]        csr_m [logic [13:0]];
    logic               line_v [`CACHE_LINES];
    logic [25:0]        line_tag [`CACHE_LINES];
    logic [31:0]        last_cnt;
    integer             seed;

    mem_top dut_i (.*);

    bind mem_top mem_asserts asserts_i (
        .clk, .rst_n, .in_valid, .stall, .wb_valid,
        .dc_req (dc_bus.req), .dc_we (dc_bus.we), .dc_byte_en (dc_bus.byte_en),
        .dc_addr (dc_bus.addr), .dc_wdata (dc_bus.wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_reg(input string name, input mem_pkg::reg_write_t exp_reg,
                             input mem_pkg::reg_write_t act);
        if (exp_reg.en ? (act !== exp_reg) : (act.addr !== 5'd0))
            abort_run($sformatf("[FAIL] t=%0d ns %s expected %h actual %h",
                                $time, name, exp_reg, act));
    endtask

    task automatic check_csr(input string name, input mem_pkg::csr_write_t exp_csr,
                             input mem_pkg::csr_write_t act);
        if (act !== exp_csr)
            abort_run($sformatf("[FAIL] t=%0d ns %s expected %h actual %h",
                                $time, name, exp_csr, act));
    endtask

    function automatic logic [31:0] csr_read(input logic [13:0] a);
        return csr_m.exists(a) ? csr_m[a] : 32'd0;
    endfunction

    function automatic void csr_write(input logic [13:0] a, input logic [31:0] d);
        if (!csr_m.exists(a))
            return;
        if (a == `CSR_ESTAT)
            csr_m[a] = (csr_m[a] & ~`ESTAT_WR_MASK) | (d & `ESTAT_WR_MASK);
        else
            csr_m[a] = d;
    endfunction

    // Predicts the write-back result and updates memory, CSR and line state
    task automatic model_step(input entry_t e, output mem_pkg::reg_write_t exp_reg,
                              output logic miss);
        logic [31:0] word;
        logic [31:0] old;
        logic [7:0]  b;
        logic [15:0] h;
        int          line;
        word = mem_m[e.addr[9:2]];
        b    = word[8*e.addr[1:0] +: 8];
        h    = e.addr[1] ? word[31:16] : word[15:0];
        old  = csr_read(e.op == mem_pkg::OP_RDCNTID ? `CSR_TID : e.caddr);
        line = int'(e.addr[5:2]);
        miss = 1'b0;
        exp_reg = '{en: 1'b1, addr: e.rd, data: e.alu};
        if (e.op inside {mem_pkg::OP_LDB, mem_pkg::OP_LDBU, mem_pkg::OP_LDH,
                         mem_pkg::OP_LDHU, mem_pkg::OP_LDW, mem_pkg::OP_LLW}) begin
            miss = !(line_v[line] && line_tag[line] == e.addr[31:6]);
            line_v[line]   = 1'b1;
            line_tag[line] = e.addr[31:6];
        end
        case (e.op)
            mem_pkg::OP_LDB:  exp_reg.data = {{24{b[7]}}, b};
            mem_pkg::OP_LDBU: exp_reg.data = {24'b0, b};
            mem_pkg::OP_LDH:  exp_reg.data = e.addr[0] ? 32'd0 : {{16{h[15]}}, h};
            mem_pkg::OP_LDHU: exp_reg.data = e.addr[0] ? 32'd0 : {16'b0, h};
            mem_pkg::OP_LDW,
            mem_pkg::OP_LLW:  exp_reg.data = word;
            mem_pkg::OP_STB: begin
                exp_reg.en = 1'b0;
                mem_m[e.addr[9:2]][8*e.addr[1:0] +: 8] = e.sdata[7:0];
            end
            mem_pkg::OP_STH: begin
                exp_reg.en = 1'b0;
                mem_m[e.addr[9:2]][16*e.addr[1] +: 16] = e.sdata[15:0];
            end
            mem_pkg::OP_STW: begin
                exp_reg.en = 1'b0;
                mem_m[e.addr[9:2]] = e.sdata;
            end
            mem_pkg::OP_CSRRD,
            mem_pkg::OP_RDCNTID: exp_reg.data = old;
            mem_pkg::OP_CSRWR: begin
                exp_reg.data = old;
                csr_write(e.caddr, e.cdata);
            end
            mem_pkg::OP_CSRXCHG: begin
                exp_reg.data = old;
                csr_write(e.caddr, (old & ~e.mask) | (e.cdata & e.mask));
            end
            mem_pkg::OP_RDCNTVH: exp_reg.data = 32'd0;   // Counter never reaches 2**32 here
            default: ;
        endcase
    endtask

    function automatic void add_entry(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                                      input logic [31:0] data, input logic [13:0] caddr,
                                      input logic [31:0] mask);
        entry_t e;
        e = '{op: op, addr: addr, sdata: data, alu: data, rd: 5'(tbl.size() % 31 + 1),
              caddr: caddr, cdata: data, mask: mask};
        tbl.push_back(e);
    endfunction

    task automatic build_table();
        logic [31:0] a;
        add_entry(mem_pkg::OP_STW, 32'h100, 32'h1122_3344, '0, '0);
        add_entry(mem_pkg::OP_STH, 32'h102, 32'h0000_aabb, '0, '0);
        add_entry(mem_pkg::OP_STB, 32'h101, 32'h0000_00cc, '0, '0);
        add_entry(mem_pkg::OP_LDW, 32'h100, '0, '0, '0);   // First touch misses
        add_entry(mem_pkg::OP_LDW, 32'h100, '0, '0, '0);
        add_entry(mem_pkg::OP_STB, 32'h100, 32'h0000_0055, '0, '0);
        add_entry(mem_pkg::OP_LLW, 32'h100, '0, '0, '0);
        add_entry(mem_pkg::OP_LDW, 32'h140, '0, '0, '0);   // Same line index, other tag
        add_entry(mem_pkg::OP_STW, 32'h200, 32'h8081_f07f, '0, '0);
        for (int off = 0; off < 4; off++) begin
            add_entry(mem_pkg::OP_LDB, 32'h200 + off, '0, '0, '0);
            add_entry(mem_pkg::OP_LDBU, 32'h200 + off, '0, '0, '0);
            add_entry(mem_pkg::OP_LDH, 32'h200 + off, '0, '0, '0);
            add_entry(mem_pkg::OP_LDHU, 32'h200 + off, '0, '0, '0);
        end
        add_entry(mem_pkg::OP_CSRRD, '0, '0, `CSR_SAVE0, '0);
        add_entry(mem_pkg::OP_CSRWR, '0, 32'h0000_1234, `CSR_SAVE0, '0);
        add_entry(mem_pkg::OP_CSRRD, '0, '0, `CSR_SAVE0, '0);   // Through forwarding
        add_entry(mem_pkg::OP_CSRXCHG, '0, 32'hffff_0000, `CSR_SAVE0, 32'h00ff_00ff);
        add_entry(mem_pkg::OP_ALU, '0, 32'hdead_beef, '0, '0);
        add_entry(mem_pkg::OP_CSRRD, '0, '0, `CSR_SAVE0, '0);
        add_entry(mem_pkg::OP_CSRWR, '0, 32'hffff_ffff, `CSR_ESTAT, '0);
        add_entry(mem_pkg::OP_CSRRD, '0, '0, `CSR_ESTAT, '0);
        add_entry(mem_pkg::OP_CSRXCHG, '0, 32'h0000_0010, `CSR_CRMD, 32'h0000_0018);
        add_entry(mem_pkg::OP_CSRRD, '0, '0, `CSR_CRMD, '0);
        add_entry(mem_pkg::OP_CSRRD, '0, '0, `CSR_ESTAT, '0);   // From the CSR file itself
        add_entry(mem_pkg::OP_CSRRD, '0, '0, `CSR_CRMD, '0);
        add_entry(mem_pkg::OP_CSRWR, '0, 32'h0000_0007, `CSR_TID, '0);
        add_entry(mem_pkg::OP_RDCNTID, '0, '0, '0, '0);
        add_entry(mem_pkg::OP_CSRWR, '0, 32'h5a5a_5a5a, 14'h3ff, '0);   // Unmapped CSR
        add_entry(mem_pkg::OP_ALU, '0, 32'h0bad_cafe, '0, '0);
        add_entry(mem_pkg::OP_CSRRD, '0, '0, 14'h3ff, '0);
        add_entry(mem_pkg::OP_RDCNTID, '0, '0, '0, '0);
        add_entry(mem_pkg::OP_RDCNTVL, '0, '0, '0, '0);
        add_entry(mem_pkg::OP_RDCNTVL, '0, '0, '0, '0);
        add_entry(mem_pkg::OP_RDCNTVH, '0, '0, '0, '0);
        seed = 32'hd627;
        for (int i = 0; i < 8; i++) begin
            a = $random(seed) & 32'h0000_03fc;
            add_entry(mem_pkg::OP_STW, a, $random(seed), '0, '0);
            a = $random(seed) & 32'h0000_03fc;
            add_entry(mem_pkg::OP_LDW, a, '0, '0, '0);
        end
    endtask

    task automatic drive(input entry_t e);
        in_valid      = 1'b1;
        in_op         = e.op;
        in_addr       = e.addr;
        in_store_data = e.sdata;
        in_alu_result = e.alu;
        in_rd         = e.rd;
        in_csr_addr   = e.caddr;
        in_csr_wdata  = e.cdata;
        in_csr_mask   = e.mask;
    endtask

    task automatic idle_inputs();
        in_valid      = 1'b0;
        in_op         = mem_pkg::OP_NONE;
        in_addr       = '0;
        in_store_data = '0;
        in_alu_result = '0;
        in_rd         = '0;
        in_csr_addr   = '0;
        in_csr_wdata  = '0;
        in_csr_mask   = '0;
    endtask

    // Returns 2 ns after the accepting edge, when write-back shows the result
    task automatic wait_accept(output logic saw_stall);
        int n;
        saw_stall = 1'b0;
        n = 0;
        @(negedge clk);
        while (stall !== 1'b0) begin
            saw_stall = 1'b1;
            n++;
            if (n > 50)
                abort_run("Timeout: stall stayed high for more than 50 cycles");
            @(negedge clk);
            if (wb_valid !== 1'b0)   // Nothing was accepted in a stalled cycle
                abort_run($sformatf("[FAIL] t=%0d ns wb_valid expected 0 actual %b",
                                    $time, wb_valid));
        end
        @(posedge clk);
        #2;
        if (wb_valid !== 1'b1)
            abort_run($sformatf("[FAIL] t=%0d ns wb_valid expected 1 actual %b",
                                $time, wb_valid));
    endtask

    initial begin
        mem_pkg::reg_write_t exp_reg;
        mem_pkg::reg_write_t act_reg;
        mem_pkg::csr_write_t exp_csr;
        mem_pkg::csr_write_t act_csr;
        logic                miss;
        logic                saw;
        rst_n = 1'b0;
        idle_inputs();
        for (int i = 0; i < `RAM_WORDS; i++)
            mem_m[i] = '0;
        for (int i = 0; i < `CACHE_LINES; i++)
            line_v[i] = 1'b0;
        csr_m[`CSR_CRMD]  = 32'h0000_0008;
        csr_m[`CSR_ESTAT] = '0;
        csr_m[`CSR_ERA]   = '0;
        csr_m[`CSR_SAVE0] = '0;
        csr_m[`CSR_TID]   = '0;
        last_cnt = '0;
        build_table();
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        foreach (tbl[i]) begin
            model_step(tbl[i], exp_reg, miss);
            drive(tbl[i]);
            wait_accept(saw);
            if (saw !== miss)
                abort_run($sformatf("[FAIL] t=%0d ns stall expected %b actual %b (entry %0d)",
                                    $time, miss, saw, i));
            if (tbl[i].op == mem_pkg::OP_CSRRD) begin
                exp_csr = '{en: 1'b1, addr: tbl[i].caddr, data: exp_reg.data};
                act_csr = '{en: wb_rd == tbl[i].rd, addr: tbl[i].caddr, data: wb_data};
                check_csr("wb_data", exp_csr, act_csr);
            end else if (tbl[i].op == mem_pkg::OP_RDCNTVL) begin
                if (wb_rd !== tbl[i].rd)
                    abort_run($sformatf("[FAIL] t=%0d ns wb_rd expected %h actual %h",
                                        $time, tbl[i].rd, wb_rd));
                if ((wb_data > last_cnt) !== 1'b1)
                    abort_run($sformatf("rdcntvl.w at %0d ns did not return a larger count",
                                        $time));
                last_cnt = wb_data;
            end else begin
                act_reg = '{en: wb_rd != 5'd0, addr: wb_rd, data: wb_data};
                check_reg("wb_rd/wb_data", exp_reg, act_reg);
            end
        end
        idle_inputs();
        @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end
endmodule
